//--- include/capture_params.svh
// width, ratio and depth macros shared by the capture path
// included by the package and by the RTL that sizes ports from them

`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// one shared FIFO word, every channel is packed up to this width
`define CAP_WORD_W 64

// narrow sample widths of the two input channels
`define CAP_CH0_W 16
`define CAP_CH1_W 32

// width of one beat on the output side of the downsizer
`define CAP_OUT_W 32

// packing ratios, derived so they track the widths above
`define CAP_UP0_RATIO (`CAP_WORD_W / `CAP_CH0_W)
`define CAP_UP1_RATIO (`CAP_WORD_W / `CAP_CH1_W)
`define CAP_DOWN_RATIO (`CAP_WORD_W / `CAP_OUT_W)

// FIFO entries, must stay a power of two for the wrap-bit pointers
`define CAP_FIFO_DEPTH 8

`endif

//--- source/capture_pkg.sv
// types shared by the capture path
// channel tag and FIFO pointer

`include "capture_params.svh"

package capture_pkg;

  // channel tag carried beside every word from the arbiter to the output
  // the encoding doubles as the arbiter's last-grant state
  typedef enum logic {
    CH0 = 1'b0,
    CH1 = 1'b1
  } chan_t;

  // index width of the FIFO storage
  localparam int FIFO_IDX_W = $clog2(`CAP_FIFO_DEPTH);

  // read and write pointer of the FIFO
  // the top bit is the wrap bit, the rest index the storage
  // equal pointers mean empty, equal index with different wrap means full
  typedef logic [FIFO_IDX_W:0] fifo_ptr_t;

endpackage

//--- source/axis_upsizer.sv
// axis_upsizer packs consecutive narrow beats into one wide word
// a last beat closes the word early, the unused upper lanes keep old data

`timescale 1ns/1ps

module axis_upsizer #(
  parameter int DWIDTH = 16,
  parameter int UP = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [DWIDTH-1:0]      in_data,
  input  logic                   in_valid,
  input  logic                   in_last,
  output logic                   in_ready,
  output logic [DWIDTH*UP-1:0]   out_data,
  output logic                   out_valid,
  output logic                   out_last,
  input  logic                   out_ready
);

  localparam int CNT_W = (UP > 1) ? $clog2(UP) : 1;

  // lane 0 holds the oldest beat of the word
  logic [UP-1:0][DWIDTH-1:0] data_reg;
  logic [CNT_W-1:0]          counter;
  logic                      in_fire;
  logic                      write_final;

  // take input only while the assembled word is gone or leaving now
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  // the word closes on its final lane or on the last beat of a burst
  assign write_final = in_fire && ((counter == CNT_W'(UP - 1)) || in_last);

  assign out_data = data_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      counter   <= '0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      // the output register only changes when it is free to change
      if (in_ready) begin
        out_valid <= write_final;
        out_last  <= write_final && in_last;
      end
      if (in_fire) begin
        if (write_final) begin
          counter <= '0;
        end else begin
          counter <= counter + 1'b1;
        end
      end
    end
  end

  // lane storage, written only on an accepted beat
  always_ff @(posedge clk) begin
    if (in_fire) begin
      data_reg[counter] <= in_data;
    end
  end

  // a stalled word must not be overwritten by new input lanes
  a_hold_word: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_data));

endmodule

//--- source/axis_downsizer.sv
// axis_downsizer splits each wide word into narrower beats
// a side-band tag is registered with the word and repeated on every beat

`timescale 1ns/1ps

module axis_downsizer #(
  parameter int DWIDTH = 64,
  parameter int DOWN = 2,
  parameter int TAG_W = 1
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [DWIDTH-1:0]        in_data,
  input  logic [TAG_W-1:0]         in_tag,
  input  logic                     in_valid,
  input  logic                     in_last,
  output logic                     in_ready,
  output logic [DWIDTH/DOWN-1:0]   out_data,
  output logic [TAG_W-1:0]         out_tag,
  output logic                     out_valid,
  output logic                     out_last,
  input  logic                     out_ready
);

  localparam int OUT_W = DWIDTH / DOWN;
  localparam int CNT_W = (DOWN > 1) ? $clog2(DOWN) : 1;

  // part 0 is the lowest slice of the word and leaves first
  logic [DOWN-1:0][OUT_W-1:0] data_reg;
  logic [TAG_W-1:0]           tag_reg;
  logic                       valid_reg;
  logic                       last_reg;
  logic [CNT_W-1:0]           counter;
  logic                       read_final;
  logic                       out_fire;

  assign read_final = (counter == CNT_W'(DOWN - 1));
  assign out_fire   = valid_reg && out_ready;

  // a new word may load when empty or as the final part goes out
  assign in_ready = !valid_reg || (read_final && out_ready);

  assign out_data  = data_reg[counter];
  assign out_tag   = tag_reg;
  assign out_valid = valid_reg;
  // only the final part of a last-marked word carries last
  assign out_last  = last_reg && read_final;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_reg <= 1'b0;
      last_reg  <= 1'b0;
      counter   <= '0;
    end else begin
      if (in_ready) begin
        valid_reg <= in_valid;
        last_reg  <= in_valid && in_last;
      end
      if (out_fire) begin
        if (read_final) begin
          counter <= '0;
        end else begin
          counter <= counter + 1'b1;
        end
      end
    end
  end

  // word and tag payload, loaded together on an accepted word
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_reg <= in_data;
      tag_reg  <= in_tag;
    end
  end

  // the part counter must wrap before it can index past the word
  a_counter_range: assert property (@(posedge clk) disable iff (reset)
    int'(counter) < DOWN);

endmodule

//--- source/capture_arbiter.sv
// capture_arbiter gives the shared FIFO write port to one of two upsizers
// round-robin between whole words, the granted side is tagged with its channel

`timescale 1ns/1ps

`include "capture_params.svh"

module capture_arbiter (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CAP_WORD_W-1:0]  w0_data,
  input  logic                    w0_valid,
  input  logic                    w0_last,
  output logic                    w0_ready,
  input  logic [`CAP_WORD_W-1:0]  w1_data,
  input  logic                    w1_valid,
  input  logic                    w1_last,
  output logic                    w1_ready,
  output logic [`CAP_WORD_W-1:0]  wr_data,
  output capture_pkg::chan_t      wr_chan,
  output logic                    wr_valid,
  output logic                    wr_last,
  input  logic                    wr_ready
);

  // channel that won the most recent transfer
  capture_pkg::chan_t last_grant;
  capture_pkg::chan_t grant;
  logic               wr_fire;

  // channel 1 wins when it is the only requester, or when both request
  // and channel 0 had the previous word
  always_comb begin
    if (w1_valid && (!w0_valid || (last_grant == capture_pkg::CH0))) begin
      grant = capture_pkg::CH1;
    end else begin
      grant = capture_pkg::CH0;
    end
  end

  assign wr_valid = w0_valid || w1_valid;
  assign wr_chan  = grant;
  assign wr_data  = (grant == capture_pkg::CH1) ? w1_data : w0_data;
  assign wr_last  = (grant == capture_pkg::CH1) ? w1_last : w0_last;

  // FIFO space goes back only to the side holding the grant
  assign w0_ready = wr_ready && (grant == capture_pkg::CH0);
  assign w1_ready = wr_ready && (grant == capture_pkg::CH1);

  assign wr_fire = wr_valid && wr_ready;

  // starting from CH1 makes channel 0 the first winner after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= capture_pkg::CH1;
    end else if (wr_fire) begin
      last_grant <= grant;
    end
  end

  a_one_ready: assert property (@(posedge clk) disable iff (reset)
    !(w0_ready && w1_ready));

  // the word written into the FIFO always comes from a requesting upsizer
  a_valid_source: assert property (@(posedge clk) disable iff (reset)
    wr_fire |-> ((grant == capture_pkg::CH0) ? w0_valid : w1_valid));

endmodule

//--- source/capture_fifo.sv
// capture_fifo is a synchronous FIFO of 64-bit words
// each entry keeps its channel tag and last flag beside the data

`timescale 1ns/1ps

`include "capture_params.svh"

module capture_fifo (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CAP_WORD_W-1:0]  wr_data,
  input  capture_pkg::chan_t      wr_chan,
  input  logic                    wr_last,
  input  logic                    wr_valid,
  output logic                    wr_ready,
  output logic [`CAP_WORD_W-1:0]  rd_data,
  output capture_pkg::chan_t      rd_chan,
  output logic                    rd_last,
  output logic                    rd_valid,
  input  logic                    rd_ready
);

  localparam int IDX_W = capture_pkg::FIFO_IDX_W;

  logic [`CAP_WORD_W-1:0] data_mem [`CAP_FIFO_DEPTH];
  capture_pkg::chan_t     chan_mem [`CAP_FIFO_DEPTH];
  logic                   last_mem [`CAP_FIFO_DEPTH];

  capture_pkg::fifo_ptr_t wr_ptr;
  capture_pkg::fifo_ptr_t rd_ptr;
  logic                   full;
  logic                   empty;
  logic                   wr_fire;
  logic                   rd_fire;

  // same index with opposite wrap bits means the writer lapped the reader
  assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                 (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign wr_ready = !full;
  assign rd_valid = !empty;
  assign wr_fire  = wr_valid && wr_ready;
  assign rd_fire  = rd_valid && rd_ready;

  // the head entry is read straight from the array
  assign rd_data = data_mem[rd_ptr[IDX_W-1:0]];
  assign rd_chan = chan_mem[rd_ptr[IDX_W-1:0]];
  assign rd_last = last_mem[rd_ptr[IDX_W-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      data_mem[wr_ptr[IDX_W-1:0]] <= wr_data;
      chan_mem[wr_ptr[IDX_W-1:0]] <= wr_chan;
      last_mem[wr_ptr[IDX_W-1:0]] <= wr_last;
    end
  end

  // a full FIFO must hold its write pointer and an empty one its read pointer
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    full |=> $stable(wr_ptr));
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    empty |=> $stable(rd_ptr));

endmodule

//--- source/capture_top.sv
// capture_top connects the two-channel capture path
// two upsizers, the round-robin arbiter, the tagged FIFO and the downsizer

`timescale 1ns/1ps

`include "capture_params.svh"

module capture_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`CAP_CH0_W-1:0]   in0_data,
  input  logic                    in0_valid,
  input  logic                    in0_last,
  output logic                    in0_ready,
  input  logic [`CAP_CH1_W-1:0]   in1_data,
  input  logic                    in1_valid,
  input  logic                    in1_last,
  output logic                    in1_ready,
  output logic [`CAP_OUT_W-1:0]   out_data,
  output capture_pkg::chan_t      out_chan,
  output logic                    out_valid,
  output logic                    out_last,
  input  logic                    out_ready
);

  // packed words from each upsizer toward the arbiter
  logic [`CAP_WORD_W-1:0] w0_data;
  logic                   w0_valid;
  logic                   w0_last;
  logic                   w0_ready;
  logic [`CAP_WORD_W-1:0] w1_data;
  logic                   w1_valid;
  logic                   w1_last;
  logic                   w1_ready;

  // shared FIFO write port
  logic [`CAP_WORD_W-1:0] wr_data;
  capture_pkg::chan_t     wr_chan;
  logic                   wr_valid;
  logic                   wr_last;
  logic                   wr_ready;

  // FIFO read side into the downsizer
  logic [`CAP_WORD_W-1:0] rd_data;
  capture_pkg::chan_t     rd_chan;
  logic                   rd_valid;
  logic                   rd_last;
  logic                   rd_ready;
  logic [0:0]             out_tag;

  // the downsizer carries the tag as plain bits, restore the channel type
  assign out_chan = capture_pkg::chan_t'(out_tag);

  axis_upsizer #(.DWIDTH(`CAP_CH0_W), .UP(`CAP_UP0_RATIO)) u_up0 (
    .clk, .reset,
    .in_data(in0_data), .in_valid(in0_valid), .in_last(in0_last), .in_ready(in0_ready),
    .out_data(w0_data), .out_valid(w0_valid), .out_last(w0_last), .out_ready(w0_ready)
  );

  axis_upsizer #(.DWIDTH(`CAP_CH1_W), .UP(`CAP_UP1_RATIO)) u_up1 (
    .clk, .reset,
    .in_data(in1_data), .in_valid(in1_valid), .in_last(in1_last), .in_ready(in1_ready),
    .out_data(w1_data), .out_valid(w1_valid), .out_last(w1_last), .out_ready(w1_ready)
  );

  capture_arbiter u_arb (
    .clk, .reset,
    .w0_data, .w0_valid, .w0_last, .w0_ready,
    .w1_data, .w1_valid, .w1_last, .w1_ready,
    .wr_data, .wr_chan, .wr_valid, .wr_last, .wr_ready
  );

  capture_fifo u_fifo (
    .clk, .reset,
    .wr_data, .wr_chan, .wr_last, .wr_valid, .wr_ready,
    .rd_data, .rd_chan, .rd_last, .rd_valid, .rd_ready
  );

  axis_downsizer #(.DWIDTH(`CAP_WORD_W), .DOWN(`CAP_DOWN_RATIO), .TAG_W(1)) u_down (
    .clk, .reset,
    .in_data(rd_data), .in_tag(rd_chan), .in_valid(rd_valid), .in_last(rd_last),
    .in_ready(rd_ready),
    .out_data, .out_tag, .out_valid, .out_last, .out_ready
  );

endmodule

//--- bench/capture_tb.sv
// capture_tb is the directed testbench for capture_top
// clock, reset, per-channel drivers, a per-channel reference model and compare tasks

`timescale 1ns/1ps

`include "capture_params.svh"

module capture_tb;

  localparam int DRIVE_DELAY = 10;
  localparam int READY_TIMEOUT = 1000;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int STALL_TIMEOUT = 200;

  logic                  clk;
  logic                  reset;
  logic [`CAP_CH0_W-1:0] in0_data;
  logic                  in0_valid;
  logic                  in0_last;
  logic                  in0_ready;
  logic [`CAP_CH1_W-1:0] in1_data;
  logic                  in1_valid;
  logic                  in1_last;
  logic                  in1_ready;
  logic [`CAP_OUT_W-1:0] out_data;
  capture_pkg::chan_t    out_chan;
  logic                  out_valid;
  logic                  out_last;
  logic                  out_ready;

  // expected beats per channel, each entry is {check data, last, data}
  logic [`CAP_OUT_W+1:0] exp0[$];
  logic [`CAP_OUT_W+1:0] exp1[$];

  int    seed = 64673;
  int    errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  string test_name = "reset";

  capture_top u_capture_top (
    .clk, .reset,
    .in0_data, .in0_valid, .in0_last, .in0_ready,
    .in1_data, .in1_valid, .in1_last, .in1_ready,
    .out_data, .out_chan, .out_valid, .out_last, .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_beat(input string test, input logic [`CAP_OUT_W-1:0] exp_data,
                            input capture_pkg::chan_t exp_chan,
                            input logic [`CAP_OUT_W-1:0] act_data,
                            input capture_pkg::chan_t act_chan);
    if (exp_data !== act_data) begin
      $display("Mismatch in %s: out_data expected %h, actual %h", test, exp_data, act_data);
      errors++;
    end
    if (exp_chan !== act_chan) begin
      $display("Mismatch in %s: out_chan expected %0d, actual %0d", test, exp_chan, act_chan);
      errors++;
    end
  endtask

  task automatic check_last(input string test, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch in %s: out_last expected %0b, actual %0b", test, exp, act);
      errors++;
    end
  endtask

  // status flags outside the data path, such as valid and ready levels
  task automatic check_flag(input string test, input string signal, input logic exp,
                            input logic act);
    if (exp !== act) begin
      $display("Mismatch in %s: %s expected %0b, actual %0b", test, signal, exp, act);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout in %s: %s", test_name, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic push_expect(input capture_pkg::chan_t chan, input logic [`CAP_OUT_W-1:0] data,
                             input logic last, input logic check);
    if (chan == capture_pkg::CH0) begin
      exp0.push_back({check, last, data});
    end else begin
      exp1.push_back({check, last, data});
    end
  endtask

  // ready only moves after a clock edge, so the falling edge sees a settled level
  task automatic wait_ready(input int chan);
    int waited;
    waited = 0;
    @(negedge clk);
    while ((chan == 0) ? !in0_ready : !in1_ready) begin
      waited++;
      if (waited > READY_TIMEOUT) begin
        stop_on_timeout($sformatf("input %0d never became ready", chan));
      end
      @(negedge clk);
    end
  endtask

  // channel 0 model packs four samples per word, two samples per output beat
  // lanes above the fill of a closed word are stale, so those beats skip the data check
  task automatic send_ch0(input int count);
    logic [`CAP_CH0_W-1:0] lanes [`CAP_UP0_RATIO];
    int fill;
    int i;
    int b;
    fill = 0;
    for (i = 0; i < count; i++) begin
      lanes[fill] = `CAP_CH0_W'($random(seed));
      in0_data = lanes[fill];
      in0_valid = 1'b1;
      in0_last = (i == count - 1);
      fill++;
      if (fill == `CAP_UP0_RATIO || in0_last) begin
        for (b = 0; b < `CAP_DOWN_RATIO; b++) begin
          push_expect(capture_pkg::CH0, {lanes[2*b+1], lanes[2*b]},
                      in0_last && (b == `CAP_DOWN_RATIO - 1), (2 * b + 1) < fill);
        end
        fill = 0;
      end
      wait_ready(0);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in0_valid = 1'b0;
    in0_last = 1'b0;
  endtask

  // channel 1 samples match the output width, each one is its own beat
  task automatic send_ch1(input int count);
    int fill;
    int i;
    fill = 0;
    for (i = 0; i < count; i++) begin
      in1_data = $random(seed);
      in1_valid = 1'b1;
      in1_last = (i == count - 1);
      fill++;
      push_expect(capture_pkg::CH1, in1_data, in1_last && (fill == 2), 1'b1);
      // a word closed after one sample still leaves a stale upper beat carrying last
      if (in1_last && fill == 1) begin
        push_expect(capture_pkg::CH1, '0, 1'b1, 1'b0);
      end
      if (fill == 2 || in1_last) begin
        fill = 0;
      end
      wait_ready(1);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in1_valid = 1'b0;
    in1_last = 1'b0;
  endtask

  // a few idle cycles after the drain catch any duplicated beat
  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp0.size() != 0 || exp1.size() != 0) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        stop_on_timeout("expected output beats never arrived");
      end
      @(negedge clk);
    end
    repeat (6) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
  endtask

  task automatic report_test(input int start_errors);
    if (errors == start_errors) begin
      tests_passed++;
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - start_errors);
    end
  endtask

  // beats are matched to a channel queue by their tag, interleaving is not predicted
  // while only one channel has beats pending, the model alone names the channel
  always @(negedge clk) begin : monitor
    logic [`CAP_OUT_W+1:0] entry;
    capture_pkg::chan_t    exp_chan;
    if (!reset && out_valid && out_ready) begin
      if (exp0.size() == 0 && exp1.size() == 0) begin
        $display("unexpected beat on channel %0d in %s with nothing left to expect",
                 out_chan, test_name);
        errors++;
      end else begin
        if (exp1.size() == 0) begin
          exp_chan = capture_pkg::CH0;
        end else if (exp0.size() == 0) begin
          exp_chan = capture_pkg::CH1;
        end else begin
          exp_chan = out_chan;
        end
        if (exp_chan == capture_pkg::CH0) begin
          entry = exp0.pop_front();
        end else begin
          entry = exp1.pop_front();
        end
        if (entry[`CAP_OUT_W+1]) begin
          check_beat(test_name, entry[`CAP_OUT_W-1:0], exp_chan, out_data, out_chan);
        end
        check_last(test_name, entry[`CAP_OUT_W], out_last);
      end
    end
  end

  task automatic test_ch0_alone();
    int start_errors;
    start_errors = errors;
    test_name = "ch0_alone";
    send_ch0(8);
    wait_drain();
    report_test(start_errors);
  endtask

  task automatic test_ch1_alone();
    int start_errors;
    start_errors = errors;
    test_name = "ch1_alone";
    send_ch1(6);
    wait_drain();
    report_test(start_errors);
  endtask

  task automatic test_both_channels();
    int start_errors;
    start_errors = errors;
    test_name = "both_channels";
    fork
      send_ch0(16);
      send_ch1(8);
    join
    wait_drain();
    report_test(start_errors);
  endtask

  // with the output blocked the FIFO fills and both upsizers end up holding a word
  task automatic test_backpressure();
    int start_errors;
    int waited;
    start_errors = errors;
    test_name = "backpressure";
    @(posedge clk);
    #DRIVE_DELAY;
    out_ready = 1'b0;
    fork
      send_ch0(32);
      send_ch1(16);
      begin
        waited = 0;
        @(negedge clk);
        while (in0_ready || in1_ready) begin
          waited++;
          if (waited > STALL_TIMEOUT) begin
            stop_on_timeout("input readys stayed high while the output was blocked");
          end
          @(negedge clk);
        end
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        out_ready = 1'b1;
      end
    join
    wait_drain();
    report_test(start_errors);
  endtask

  // six samples close the second word after two lanes
  task automatic test_early_last();
    int start_errors;
    start_errors = errors;
    test_name = "early_last";
    send_ch0(6);
    wait_drain();
    report_test(start_errors);
  endtask

  // a channel 1 word is left waiting at the blocked output, so reset has state to clear
  task automatic test_reset_state();
    int start_errors;
    start_errors = errors;
    test_name = "reset_state";
    out_ready = 1'b0;
    send_ch1(2);
    repeat (4) @(negedge clk);
    check_flag(test_name, "out_valid before reset", 1'b1, out_valid);
    apply_reset();
    exp1.delete();
    out_ready = 1'b1;
    @(negedge clk);
    check_flag(test_name, "out_valid", 1'b0, out_valid);
    check_flag(test_name, "in0_ready", 1'b1, in0_ready);
    check_flag(test_name, "in1_ready", 1'b1, in1_ready);
    report_test(start_errors);
  endtask

  initial begin
    reset = 1'b1;
    in0_data = '0;
    in0_valid = 1'b0;
    in0_last = 1'b0;
    in1_data = '0;
    in1_valid = 1'b0;
    in1_last = 1'b0;
    out_ready = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    test_ch0_alone();
    test_ch1_alone();
    test_both_channels();
    test_backpressure();
    test_early_last();
    test_reset_state();
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- capture_top.f
+incdir+include
source/capture_pkg.sv
source/axis_upsizer.sv
source/axis_downsizer.sv
source/capture_arbiter.sv
source/capture_fifo.sv
source/capture_top.sv
bench/capture_tb.sv

//--- Makefile
# Verilator build and run for the capture path testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= capture_tb
FILELIST ?= capture_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# the binary is rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
